// ==== design/ptw_pkg.sv ====
// Shared definitions for the Sv39 IOMMU page table walker
// Widths, PTE layout, walk enums and cause codes
// Imported by the interface and every walker module

package ptw_pkg;

    // Sv39 address widths
    localparam int VLEN           = 39;
    localparam int PLEN           = 56;
    localparam int PPNW           = 44;
    localparam int VPNW           = 27;
    localparam int VPN_SEG        = 9;
    localparam int PSCIDW         = 20;
    localparam int PAGE_OFS       = 12;
    localparam int PTE_BYTES_LOG2 = 3;

    // Sv39 page table entry, top bit first
    typedef struct packed {
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // Walk level, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } lvl_e;

    // Walker FSM states
    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } state_e;

    // Checker verdict for one fetched PTE
    typedef enum logic [1:0] {
        PTE_POINTER,
        PTE_LEAF,
        PTE_FAULT
    } pte_kind_e;

    // Fault causes reported with ptw_error_o
    typedef enum logic [7:0] {
        CAUSE_NONE         = 8'd0,
        LOAD_PAGE_FAULT    = 8'd13,
        STORE_PAGE_FAULT   = 8'd15,
        PT_DATA_CORRUPTION = 8'd19
    } cause_e;

endpackage

// ==== design/ptw_pte_if.sv ====
// PTE check channel between the walk controller and the PTE checker
// Controller side drives the PTE and its context, checker side the verdict
// Verdict is combinational and valid in the same cycle as the PTE

`timescale 1ns/100ps

interface ptw_pte_if import ptw_pkg::*; ();

    // Fetched PTE and the walk context it is checked in
    pte_t      pte;
    lvl_e      level;
    logic      is_store;

    // Verdict from the checker
    pte_kind_e kind;
    logic      is_global;

    // Walk controller side
    modport ctrl (output pte, output level, output is_store, input kind, input is_global);

    // Checker side
    modport chk (input pte, input level, input is_store, output kind, output is_global);

endinterface

// ==== design/ptw_pte_check.sv ====
// Combinational Sv39 PTE checker
// Classifies the PTE on the interface as pointer, leaf or fault
// for the current walk level and access type, with zero latency

`timescale 1ns/100ps

module ptw_pte_check import ptw_pkg::*; (
    ptw_pte_if.chk pte_if
);

    // Encoding errors common to every PTE
    logic bad_format;
    // Leaf when readable or executable
    logic is_leaf;
    // Leaf rule violations
    logic leaf_perm_fault;
    logic leaf_misaligned;
    // Pointer rule violations
    logic ptr_fault;

    // Invalid, write-only or reserved bits in use
    assign bad_format = !pte_if.pte.v
                     || (pte_if.pte.w && !pte_if.pte.r)
                     || (|pte_if.pte.reserved);

    assign is_leaf = pte_if.pte.r || pte_if.pte.x;

    // Accessed bit must be set, stores also need the dirty bit
    // Execute-only leaves are not usable for DMA reads
    assign leaf_perm_fault = !pte_if.pte.a
                          || !pte_if.pte.r
                          || (pte_if.is_store && !pte_if.pte.d);

    // Superpage ppn must be aligned to the page size
    always_comb begin
        leaf_misaligned = 1'b0;
        case (pte_if.level)
            LVL1: leaf_misaligned = |pte_if.pte.ppn[2*VPN_SEG-1:0];
            LVL2: leaf_misaligned = |pte_if.pte.ppn[VPN_SEG-1:0];
            default: leaf_misaligned = 1'b0;
        endcase
    end

    // A, D and U are reserved in non-leaf entries
    // No table exists below the last level
    assign ptr_fault = pte_if.pte.a
                    || pte_if.pte.d
                    || pte_if.pte.u
                    || (pte_if.level == LVL3);

    // Verdict in Sv39 rule order
    always_comb begin
        if (bad_format) begin
            pte_if.kind = PTE_FAULT;
        end else if (is_leaf) begin
            if (leaf_perm_fault || leaf_misaligned) begin
                pte_if.kind = PTE_FAULT;
            end else begin
                pte_if.kind = PTE_LEAF;
            end
        end else if (ptr_fault) begin
            pte_if.kind = PTE_FAULT;
        end else begin
            pte_if.kind = PTE_POINTER;
        end
    end

    // Global mapping bit of this entry
    assign pte_if.is_global = pte_if.pte.g;

endmodule

// ==== design/ptw_walk_ctrl.sv ====
// Sv39 walk controller
// Starts a walk on a rising trigger edge, issues one read per level,
// follows pointer PTEs and ends with an IOTLB update or an error pulse

`timescale 1ns/100ps

module ptw_walk_ctrl import ptw_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Walk request
    input  logic              init_ptw_i,
    input  logic              is_store_i,
    input  logic [VLEN-1:0]   req_iova_i,
    input  logic [PSCIDW-1:0] pscid_i,
    input  logic [PPNW-1:0]   iosatp_ppn_i,
    // Walk status
    output logic              ptw_active_o,
    output logic              ptw_error_o,
    output cause_e            cause_code_o,
    // Read request and response handshakes
    output logic              mem_ar_valid_o,
    input  logic              mem_ar_ready_i,
    output logic [PLEN-1:0]   mem_ar_addr_o,
    input  logic              mem_r_valid_i,
    output logic              mem_r_ready_o,
    input  logic              mem_r_err_i,
    input  pte_t              pte_i,
    // IOTLB update
    output logic              update_o,
    output logic              up_2m_o,
    output logic              up_1g_o,
    output logic [VPNW-1:0]   up_vpn_o,
    output logic [PSCIDW-1:0] up_pscid_o,
    output pte_t              up_pte_o,
    // PTE checker channel
    ptw_pte_if.ctrl           pte_if
);

    // Control state
    state_e state_q, state_d;
    lvl_e   lvl_q, lvl_d;
    logic   trig_q;
    logic   glob_q, glob_d;
    logic   pf_q, pf_d;

    // Captured request and current table pointer
    logic [PLEN-1:0]   pptr_q, pptr_d;
    logic [VLEN-1:0]   iova_q, iova_d;
    logic [PSCIDW-1:0] pscid_q, pscid_d;
    logic              store_q, store_d;

    logic               start;
    logic               beat;
    logic [VPN_SEG-1:0] next_seg;

    // Rising edge of the trigger while idle
    assign start = init_ptw_i && !trig_q && (state_q == IDLE);

    // Response beat consumed this cycle
    assign beat = (state_q == PROC_PTE) && mem_r_valid_i;

    // Index into the next table, LVL1 uses VPN[1], LVL2 uses VPN[0]
    assign next_seg = (lvl_q == LVL1) ? iova_q[PAGE_OFS+VPN_SEG +: VPN_SEG]
                                      : iova_q[PAGE_OFS +: VPN_SEG];

    // PTE goes straight from the read data to the checker
    assign pte_if.pte      = pte_i;
    assign pte_if.level    = lvl_q;
    assign pte_if.is_store = store_q;

    always_comb begin
        state_d = state_q;
        lvl_d   = lvl_q;
        glob_d  = glob_q;
        pf_d    = pf_q;
        pptr_d  = pptr_q;
        iova_d  = iova_q;
        pscid_d = pscid_q;
        store_d = store_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = MEM_ACCESS;
                    lvl_d   = LVL1;
                    glob_d  = 1'b0;
                    pf_d    = 1'b0;
                    // Root table indexed by VPN[2]
                    pptr_d  = {iosatp_ppn_i, req_iova_i[VLEN-1 -: VPN_SEG],
                               {PTE_BYTES_LOG2{1'b0}}};
                    iova_d  = req_iova_i;
                    pscid_d = pscid_i;
                    store_d = is_store_i;
                end
            end
            MEM_ACCESS: begin
                if (mem_ar_ready_i) begin
                    state_d = PROC_PTE;
                end
            end
            PROC_PTE: begin
                if (mem_r_valid_i) begin
                    // Bus error wins over any verdict
                    if (mem_r_err_i) begin
                        state_d = ERROR;
                        pf_d    = 1'b0;
                    end else begin
                        case (pte_if.kind)
                            PTE_POINTER: begin
                                state_d = MEM_ACCESS;
                                lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
                                glob_d  = glob_q | pte_if.is_global;
                                pptr_d  = {pte_i.ppn, next_seg, {PTE_BYTES_LOG2{1'b0}}};
                            end
                            PTE_LEAF: state_d = IDLE;
                            default: begin
                                state_d = ERROR;
                                pf_d    = 1'b1;
                            end
                        endcase
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
            trig_q  <= 1'b0;
            glob_q  <= 1'b0;
            pf_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            lvl_q   <= lvl_d;
            trig_q  <= init_ptw_i;
            glob_q  <= glob_d;
            pf_q    <= pf_d;
        end
    end

    // Request payload, only read while a walk is active
    always_ff @(posedge clk_i) begin
        pptr_q  <= pptr_d;
        iova_q  <= iova_d;
        pscid_q <= pscid_d;
        store_q <= store_d;
    end

    // Handshakes
    assign mem_ar_valid_o = (state_q == MEM_ACCESS);
    assign mem_ar_addr_o  = pptr_q;
    assign mem_r_ready_o  = beat;
    assign ptw_active_o   = (state_q != IDLE);

    // Leaf accepted on a clean beat
    assign update_o   = beat && !mem_r_err_i && (pte_if.kind == PTE_LEAF);
    assign up_vpn_o   = iova_q[VLEN-1:PAGE_OFS];
    assign up_pscid_o = pscid_q;
    assign up_1g_o    = (lvl_q == LVL1);
    assign up_2m_o    = (lvl_q == LVL2);

    // Global if any table on the path or the leaf itself is global
    always_comb begin
        up_pte_o   = pte_i;
        up_pte_o.g = glob_q | pte_if.is_global;
    end

    // Error pulse one cycle after the faulting beat
    assign ptw_error_o = (state_q == ERROR);

    always_comb begin
        if (state_q != ERROR) begin
            cause_code_o = CAUSE_NONE;
        end else if (!pf_q) begin
            cause_code_o = PT_DATA_CORRUPTION;
        end else if (store_q) begin
            cause_code_o = STORE_PAGE_FAULT;
        end else begin
            cause_code_o = LOAD_PAGE_FAULT;
        end
    end

endmodule

// ==== design/ptw_top.sv ====
// Top level of the Sv39 IOMMU page table walker
// Plain ports to the IOTLB and the memory read port,
// connects the walk controller to the PTE checker

`timescale 1ns/100ps

module ptw_top import ptw_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Walk request from the IOTLB miss path
    input  logic              init_ptw_i,
    input  logic              is_store_i,
    input  logic [VLEN-1:0]   req_iova_i,
    input  logic [PSCIDW-1:0] pscid_i,
    input  logic [PPNW-1:0]   iosatp_ppn_i,
    // Walk status
    output logic              ptw_active_o,
    output logic              ptw_error_o,
    output cause_e            cause_code_o,
    // Memory read port
    output logic              mem_ar_valid_o,
    input  logic              mem_ar_ready_i,
    output logic [PLEN-1:0]   mem_ar_addr_o,
    input  logic              mem_r_valid_i,
    output logic              mem_r_ready_o,
    input  pte_t              mem_r_data_i,
    input  logic              mem_r_err_i,
    // IOTLB update
    output logic              update_o,
    output logic              up_2m_o,
    output logic              up_1g_o,
    output logic [VPNW-1:0]   up_vpn_o,
    output logic [PSCIDW-1:0] up_pscid_o,
    output pte_t              up_pte_o
);

    // PTE and verdict between controller and checker
    ptw_pte_if pte_if ();

    ptw_walk_ctrl u_walk_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_ptw_i     (init_ptw_i),
        .is_store_i     (is_store_i),
        .req_iova_i     (req_iova_i),
        .pscid_i        (pscid_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .ptw_active_o   (ptw_active_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .mem_r_err_i    (mem_r_err_i),
        .pte_i          (mem_r_data_i),
        .update_o       (update_o),
        .up_2m_o        (up_2m_o),
        .up_1g_o        (up_1g_o),
        .up_vpn_o       (up_vpn_o),
        .up_pscid_o     (up_pscid_o),
        .up_pte_o       (up_pte_o),
        .pte_if         (pte_if.ctrl)
    );

    ptw_pte_check u_pte_check (
        .pte_if (pte_if.chk)
    );

endmodule

// ==== test/ptw_sva.sv ====
// Handshake and output rules for the page table walker
// Bound into every ptw_top instance, reports through failing assertions

`timescale 1ns/100ps

module ptw_sva import ptw_pkg::*; (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            ar_valid_i,
    input logic            ar_ready_i,
    input logic [PLEN-1:0] ar_addr_i,
    input logic            update_i,
    input logic            error_i,
    input logic            active_i
);

    // Request holds with a stable address until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else $error("read request dropped or changed before ready");

    // A walk ends either with an update or with an error
    end_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_i && error_i))
        else $error("update and error pulses raised together");

    // Requests only while a walk is active
    ar_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i |-> active_i)
        else $error("read request while the walker is idle");

endmodule

bind ptw_top ptw_sva u_ptw_sva (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_valid_i (mem_ar_valid_o),
    .ar_ready_i (mem_ar_ready_i),
    .ar_addr_i  (mem_ar_addr_o),
    .update_i   (update_o),
    .error_i    (ptw_error_o),
    .active_i   (ptw_active_o)
);

// ==== test/tb_ptw.sv ====
// Directed testbench for the Sv39 page table walker
// A memory model with random handshake delays serves PTEs from a sparse table,
// each test builds its tables, starts one walk and checks the IOTLB update or error

`timescale 1ns/100ps

module tb_ptw import ptw_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 2000
) ();

    // PTE flag bits d a g u x w r v
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_G = 8'h20;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    // Common request used by most tests
    localparam logic [PPNW-1:0]    ROOT = 44'h00080;
    localparam logic [VPN_SEG-1:0] SEG2 = 9'h0a5;
    localparam logic [VPN_SEG-1:0] SEG1 = 9'h13c;
    localparam logic [VPN_SEG-1:0] SEG0 = 9'h1f0;
    localparam logic [VLEN-1:0]    IOVA = {SEG2, SEG1, SEG0, 12'h345};

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              init_ptw_i, is_store_i;
    logic [VLEN-1:0]   req_iova_i;
    logic [PSCIDW-1:0] pscid_i;
    logic [PPNW-1:0]   iosatp_ppn_i;
    logic              ptw_active_o, ptw_error_o;
    cause_e            cause_code_o;
    logic              mem_ar_valid_o, mem_ar_ready_i;
    logic [PLEN-1:0]   mem_ar_addr_o;
    logic              mem_r_valid_i, mem_r_ready_o, mem_r_err_i;
    pte_t              mem_r_data_i;
    logic              update_o, up_2m_o, up_1g_o;
    logic [VPNW-1:0]   up_vpn_o;
    logic [PSCIDW-1:0] up_pscid_o;
    pte_t              up_pte_o;

    // Sparse page table memory and bus error map, keyed by byte address
    pte_t            mem [logic [PLEN-1:0]];
    bit              bus_err [logic [PLEN-1:0]];
    logic [PLEN-1:0] req_q [$];
    logic [PLEN-1:0] resp_addr;
    logic [31:0]     rng_state = 32'ha19a;
    int              mem_phase, ar_wait, r_wait;
    // Response beats the walker accepted in the current walk
    int              beats_taken = 0;
    int              cycles = 0;
    int              errors = 0;

    // Outcome of the last walk
    logic              got_update, got_error, got_1g, got_2m;
    cause_e            got_cause;
    logic [VPNW-1:0]   got_vpn;
    logic [PSCIDW-1:0] got_pscid;
    pte_t              got_pte;

    ptw_top dut (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Handshake delay of 0 to 3 cycles
    task automatic draw_delay(output int d);
        rng_state = xorshift(rng_state);
        d = int'(rng_state[1:0]);
    endtask

    function automatic pte_t make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] flags);
        pte_t p;
        p = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    // Table base from the PPN plus the entry index times 8
    function automatic logic [PLEN-1:0] pte_addr(input logic [PPNW-1:0] ppn,
                                                 input logic [VPN_SEG-1:0] idx);
        return {ppn, idx, 3'b000};
    endfunction

    // Memory model serving one request at a time
    // Phase 0 waits for a request, phase 1 delays the response and phase 2 drops the beat
    initial begin
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_data_i   = '0;
        mem_r_err_i    = 1'b0;
        mem_phase      = 0;
        draw_delay(ar_wait);
        forever begin
            @(negedge clk_i);
            case (mem_phase)
                0: begin
                    if (mem_ar_valid_o && ar_wait == 0) begin
                        mem_ar_ready_i = 1'b1;
                        resp_addr = mem_ar_addr_o;
                        req_q.push_back(mem_ar_addr_o);
                        draw_delay(r_wait);
                        mem_phase = 1;
                    end else if (mem_ar_valid_o) begin
                        ar_wait--;
                    end
                end
                1: begin
                    mem_ar_ready_i = 1'b0;
                    if (r_wait == 0) begin
                        mem_r_valid_i = 1'b1;
                        mem_r_data_i  = mem.exists(resp_addr) ? mem[resp_addr] : '0;
                        mem_r_err_i   = (bus_err.exists(resp_addr) != 0);
                        mem_phase = 2;
                        // Ready follows valid within the same cycle
                        #1;
                        if (mem_r_ready_o) begin
                            beats_taken++;
                        end
                    end else begin
                        r_wait--;
                    end
                end
                default: begin
                    // Beat is dropped after one cycle
                    mem_r_valid_i = 1'b0;
                    mem_r_data_i  = '0;
                    mem_r_err_i   = 1'b0;
                    draw_delay(ar_wait);
                    mem_phase = 0;
                end
            endcase
        end
    end

    task automatic check_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic clear_tables();
        mem.delete();
        bus_err.delete();
    endtask

    // Start one walk on a rising trigger, wait for the update or error pulse
    task automatic run_walk(input logic [VLEN-1:0] iova, input logic [PSCIDW-1:0] pscid,
                            input logic store, input logic [PPNW-1:0] root,
                            input logic hold);
        req_q.delete();
        beats_taken = 0;
        got_update = 1'b0;
        got_error  = 1'b0;
        @(negedge clk_i);
        req_iova_i   = iova;
        pscid_i      = pscid;
        is_store_i   = store;
        iosatp_ppn_i = root;
        init_ptw_i   = 1'b1;
        while (!got_update && !got_error) begin
            @(negedge clk_i);
            if (!hold) init_ptw_i = 1'b0;
            // Pulses are stable in the middle of the low phase
            #5;
            if (update_o) begin
                got_update = 1'b1;
                got_vpn    = up_vpn_o;
                got_pscid  = up_pscid_o;
                got_pte    = up_pte_o;
                got_1g     = up_1g_o;
                got_2m     = up_2m_o;
            end
            if (ptw_error_o) begin
                got_error = 1'b1;
                got_cause = cause_code_o;
            end
        end
    endtask

    task automatic check_requests(input string name, input int n, input logic [PLEN-1:0] a0,
                                  input logic [PLEN-1:0] a1, input logic [PLEN-1:0] a2);
        logic [PLEN-1:0] exp [3];
        exp = '{a0, a1, a2};
        check_equal({name, " request count"}, 64'(n), 64'(req_q.size()));
        for (int i = 0; i < n; i++) begin
            check_equal({name, " request address"}, 64'(exp[i]), 64'(req_q[i]));
        end
    endtask

    task automatic expect_update(input string name, input logic [PSCIDW-1:0] pscid,
                                 input pte_t pte, input logic is_1g, input logic is_2m);
        check_equal({name, " update"}, 64'd1, 64'(got_update));
        check_equal({name, " beats taken"}, 64'(req_q.size()), 64'(beats_taken));
        check_equal({name, " vpn"}, 64'(IOVA[VLEN-1:PAGE_OFS]), 64'(got_vpn));
        check_equal({name, " pscid"}, 64'(pscid), 64'(got_pscid));
        check_equal({name, " pte"}, 64'(pte), 64'(got_pte));
        check_equal({name, " 1g"}, 64'(is_1g), 64'(got_1g));
        check_equal({name, " 2m"}, 64'(is_2m), 64'(got_2m));
    endtask

    task automatic expect_fault(input string name, input cause_e cause);
        check_equal({name, " error"}, 64'd1, 64'(got_error));
        check_equal({name, " no update"}, 64'd0, 64'(got_update));
        check_equal({name, " beats taken"}, 64'(req_q.size()), 64'(beats_taken));
        check_equal({name, " cause"}, 64'(cause), 64'(got_cause));
    endtask

    task automatic test_4k_load();
        pte_t leaf;
        leaf = make_pte(44'h789ab, F_V | F_R | F_W | F_A | F_D);
        clear_tables();
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00123, F_V);
        mem[pte_addr(44'h00123, SEG1)] = make_pte(44'h00456, F_V);
        mem[pte_addr(44'h00456, SEG0)] = leaf;
        run_walk(IOVA, 20'h0beef, 1'b0, ROOT, 1'b0);
        check_requests("4k_load", 3, pte_addr(ROOT, SEG2), pte_addr(44'h00123, SEG1),
                       pte_addr(44'h00456, SEG0));
        expect_update("4k_load", 20'h0beef, leaf, 1'b0, 1'b0);
    endtask

    task automatic test_superpages();
        pte_t leaf_1g, leaf_2m;
        leaf_1g = make_pte(44'h40000, F_V | F_R | F_X | F_A);
        leaf_2m = make_pte(44'h00600, F_V | F_R | F_W | F_A | F_D);
        clear_tables();
        mem[pte_addr(ROOT, SEG2)] = leaf_1g;
        run_walk(IOVA, 20'h00001, 1'b0, ROOT, 1'b0);
        check_requests("leaf_1g", 1, pte_addr(ROOT, SEG2), '0, '0);
        expect_update("leaf_1g", 20'h00001, leaf_1g, 1'b1, 1'b0);
        // 2M leaf reached through one pointer on a store
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00200, F_V);
        mem[pte_addr(44'h00200, SEG1)] = leaf_2m;
        run_walk(IOVA, 20'h00002, 1'b1, ROOT, 1'b0);
        check_requests("leaf_2m", 2, pte_addr(ROOT, SEG2), pte_addr(44'h00200, SEG1), '0);
        expect_update("leaf_2m", 20'h00002, leaf_2m, 1'b0, 1'b1);
    endtask

    task automatic test_global();
        pte_t leaf, exp;
        leaf = make_pte(44'h0abcd, F_V | F_R | F_A);
        exp = leaf;
        exp.g = 1'b1;
        clear_tables();
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00300, F_V | F_G);
        mem[pte_addr(44'h00300, SEG1)] = make_pte(44'h00301, F_V);
        mem[pte_addr(44'h00301, SEG0)] = leaf;
        run_walk(IOVA, 20'h00003, 1'b0, ROOT, 1'b0);
        expect_update("global", 20'h00003, exp, 1'b0, 1'b0);
    endtask

    task automatic test_page_faults();
        // Empty root table reads back an invalid PTE
        clear_tables();
        run_walk(IOVA, 20'h00004, 1'b0, ROOT, 1'b0);
        check_requests("invalid_pte", 1, pte_addr(ROOT, SEG2), '0, '0);
        expect_fault("invalid_pte", LOAD_PAGE_FAULT);
        // Store to a clean 2M leaf
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00310, F_V);
        mem[pte_addr(44'h00310, SEG1)] = make_pte(44'h00a00, F_V | F_R | F_W | F_A);
        run_walk(IOVA, 20'h00005, 1'b1, ROOT, 1'b0);
        expect_fault("store_clean", STORE_PAGE_FAULT);
        // Pointer found in the last level table
        clear_tables();
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00321, F_V);
        mem[pte_addr(44'h00321, SEG1)] = make_pte(44'h00654, F_V);
        mem[pte_addr(44'h00654, SEG0)] = make_pte(44'h00999, F_V);
        run_walk(IOVA, 20'h00006, 1'b0, ROOT, 1'b0);
        check_requests("ptr_lvl3", 3, pte_addr(ROOT, SEG2), pte_addr(44'h00321, SEG1),
                       pte_addr(44'h00654, SEG0));
        expect_fault("ptr_lvl3", LOAD_PAGE_FAULT);
    endtask

    task automatic test_misaligned_2m();
        clear_tables();
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00210, F_V);
        mem[pte_addr(44'h00210, SEG1)] = make_pte(44'h00601, F_V | F_R | F_A);
        run_walk(IOVA, 20'h00007, 1'b0, ROOT, 1'b0);
        check_requests("misaligned_2m", 2, pte_addr(ROOT, SEG2), pte_addr(44'h00210, SEG1), '0);
        expect_fault("misaligned_2m", LOAD_PAGE_FAULT);
    endtask

    task automatic test_bus_error_and_edge();
        clear_tables();
        mem[pte_addr(ROOT, SEG2)] = make_pte(44'h00777, F_V);
        // Good leaf data but the beat carries a bus error
        mem[pte_addr(44'h00777, SEG1)] = make_pte(44'h00800, F_V | F_R | F_W | F_A | F_D);
        bus_err[pte_addr(44'h00777, SEG1)] = 1'b1;
        run_walk(IOVA, 20'h00008, 1'b1, ROOT, 1'b1);
        expect_fault("bus_error", PT_DATA_CORRUPTION);
        // Trigger is still high so no second walk may start
        repeat (10) begin
            @(negedge clk_i);
            #5;
            check_equal("held_trigger idle", 64'd0, 64'({mem_ar_valid_o, ptw_active_o}));
        end
        check_equal("held_trigger requests", 64'd2, 64'(req_q.size()));
        @(negedge clk_i);
        init_ptw_i = 1'b0;
    endtask

    initial begin
        rst_ni       = 1'b0;
        init_ptw_i   = 1'b0;
        is_store_i   = 1'b0;
        req_iova_i   = '0;
        pscid_i      = '0;
        iosatp_ppn_i = '0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #5;
        check_equal("reset outputs", 64'd0,
                    64'({mem_ar_valid_o, mem_r_ready_o, update_o, ptw_error_o, ptw_active_o}));
        test_4k_load();
        test_superpages();
        test_global();
        test_page_faults();
        test_misaligned_2m();
        test_bus_error_and_edge();
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== iommu_ptw.f ====
design/ptw_pkg.sv
design/ptw_pte_if.sv
design/ptw_pte_check.sv
design/ptw_walk_ctrl.sv
design/ptw_top.sv
test/ptw_sva.sv
test/tb_ptw.sv

// ==== Makefile ====
# Verilator build and run of the page table walker testbench
VERILATOR ?= verilator
TOP       ?= tb_ptw
FILELIST  ?= iommu_ptw.f
TIMEOUT   ?= 2000
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST TIMEOUT BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GTIMEOUT_CYCLES=$(TIMEOUT) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)
